/* src/harnessPkg.sv */
// Shared definitions for the path-ORAM traffic harness
// Command codes and default widths used by RTL and testbench

package harnessPkg;

	// --------------------
	// Command encodings
	// --------------------

	// Width of the command field in a packet
	parameter int CmdWidth = 2;

	// Backend commands
	parameter logic [CmdWidth-1:0] BecmdRead = 2'd0;
	parameter logic [CmdWidth-1:0] BecmdUpdate = 2'd1;
	parameter logic [CmdWidth-1:0] BecmdAppend = 2'd2;

	// Harness-only code, consumed by the packet buffer
	parameter logic [CmdWidth-1:0] TcmdStart = 2'd3;

	// --------------------
	// Default sizes
	// --------------------

	// Leaf address bits
	parameter int DefOramU = 8;
	// One data chunk, also the seed width
	parameter int DefDBaseWidth = 16;
	// Backend data bus, two chunks per word
	parameter int DefFedWidth = 32;
	// Chunks in one block
	parameter int DefBlkChunks = 8;
	// Delay field bits
	parameter int DefTimeWidth = 8;
	// Packet FIFO depth
	parameter int DefBuffering = 16;

endpackage

/* src/packetBuffer.sv */
// Packet FIFO ahead of the backend command path
// Holds packets until a start packet opens the burst gate
`timescale 1ns/100ps

module packetBuffer #(
	parameter int OramU = harnessPkg::DefOramU,
	parameter int DBaseWidth = harnessPkg::DefDBaseWidth,
	parameter int TimeWidth = harnessPkg::DefTimeWidth,
	parameter int Buffering = harnessPkg::DefBuffering
) (
	input logic Clock,
	input logic arstN,
	input logic [harnessPkg::CmdWidth+OramU+DBaseWidth+TimeWidth-1:0] PacketData,
	input logic PacketValid,
	output logic PacketReady,
	output logic [harnessPkg::CmdWidth-1:0] headCmd,
	output logic [OramU-1:0] headPAddr,
	output logic [DBaseWidth-1:0] headBase,
	output logic [TimeWidth-1:0] headDelay,
	output logic headValid,
	input logic headReady,
	output logic ErrorSendOverflow
);
	import harnessPkg::*;

	localparam int PacketWidth = CmdWidth + OramU + DBaseWidth + TimeWidth;
	localparam int PtrWidth = (Buffering > 1) ? $clog2(Buffering) : 1;
	localparam int CntWidth = $clog2(Buffering + 1);

	logic [PacketWidth-1:0] fifoMem [Buffering];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CntWidth-1:0] fillCount;
	logic running;
	logic gateOpen;
	logic isStart;
	logic startSeen;
	logic fifoFull;
	logic fifoEmpty;
	logic pushEn;
	logic popEn;

	// Circular pointer step, wraps at depth
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		return (ptr == PtrWidth'(Buffering - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Command field sits on top of the packet word
	assign isStart = PacketData[PacketWidth-1 -: CmdWidth] == TcmdStart;
	assign fifoFull = fillCount == CntWidth'(Buffering);
	assign fifoEmpty = fillCount == '0;

	// Ready only once out of reset
	assign PacketReady = running & ~fifoFull;
	// Start packets bypass the FIFO, even when full
	assign startSeen = PacketValid & running & isStart;
	assign pushEn = PacketValid & PacketReady & ~isStart;

	// --------------------
	// Head of FIFO toward the issuer
	// --------------------

	assign headValid = gateOpen & ~fifoEmpty;
	assign popEn = headValid & headReady;
	assign {headCmd, headPAddr, headBase, headDelay} = fifoMem[rdPtr];

	// Storage, payload only
	always_ff @(posedge Clock) begin
		if (pushEn) begin
			fifoMem[wrPtr] <= PacketData;
		end
	end

	// Pointers and fill level
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
			wrPtr <= '0;
			rdPtr <= '0;
			fillCount <= '0;
		end else begin
			running <= 1'b1;
			if (pushEn) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (popEn) begin
				rdPtr <= nextPtr(rdPtr);
			end
			if (pushEn && !popEn) begin
				fillCount <= fillCount + CntWidth'(1);
			end else if (popEn && !pushEn) begin
				fillCount <= fillCount - CntWidth'(1);
			end
		end
	end

	// Burst gate; closes once drained, repeated start ignored while open
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			gateOpen <= 1'b0;
		end else if (gateOpen) begin
			if (fifoEmpty) begin
				gateOpen <= 1'b0;
			end
		end else if (startSeen) begin
			gateOpen <= 1'b1;
		end
	end

	// Sticky overflow, packet dropped
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			ErrorSendOverflow <= 1'b0;
		end else if (PacketValid && fifoFull && !isStart) begin
			ErrorSendOverflow <= 1'b1;
		end
	end

endmodule

/* src/commandIssuer.sv */
// Backend command issue stage
// One-entry holding register released by the time gate and the write gate
`timescale 1ns/100ps

module commandIssuer #(
	parameter int OramU = harnessPkg::DefOramU,
	parameter int DBaseWidth = harnessPkg::DefDBaseWidth,
	parameter int TimeWidth = harnessPkg::DefTimeWidth
) (
	input logic Clock,
	input logic arstN,
	input logic [harnessPkg::CmdWidth-1:0] headCmd,
	input logic [OramU-1:0] headPAddr,
	input logic [DBaseWidth-1:0] headBase,
	input logic [TimeWidth-1:0] headDelay,
	input logic headValid,
	output logic headReady,
	output logic [harnessPkg::CmdWidth-1:0] ORAMCommand,
	output logic [OramU-1:0] ORAMPAddr,
	output logic ORAMCommandValid,
	input logic ORAMCommandReady,
	input logic writeDone,
	output logic holdWrite,
	output logic [DBaseWidth-1:0] holdBase,
	output logic cmdTransfer
);
	import harnessPkg::*;

	logic holdValid;
	logic [TimeWidth-1:0] holdDelay;
	logic [TimeWidth-1:0] packetAge;
	logic loadEn;
	logic timeGate;
	logic writeGate;

	// Take a new head only when the register is empty
	assign headReady = ~holdValid;
	assign loadEn = headValid & headReady;

	// --------------------
	// Gates
	// --------------------

	// Time gate opens once the packet has aged its delay
	assign timeGate = packetAge >= holdDelay;

	// Writes wait for their data block
	assign holdWrite = holdValid & ((ORAMCommand == BecmdUpdate) | (ORAMCommand == BecmdAppend));
	assign writeGate = ~holdWrite | writeDone;

	assign ORAMCommandValid = holdValid & timeGate & writeGate;
	assign cmdTransfer = ORAMCommandValid & ORAMCommandReady;

	// Held packet fields
	always_ff @(posedge Clock) begin
		if (loadEn) begin
			ORAMCommand <= headCmd;
			ORAMPAddr <= headPAddr;
			holdBase <= headBase;
			holdDelay <= headDelay;
		end
	end

	// Occupancy; empties on the command transfer itself
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			holdValid <= 1'b0;
		end else if (loadEn) begin
			holdValid <= 1'b1;
		end else if (cmdTransfer) begin
			holdValid <= 1'b0;
		end
	end

	// Age from zero after load, stops at the delay
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			packetAge <= '0;
		end else if (loadEn) begin
			packetAge <= '0;
		end else if (holdValid && !timeGate) begin
			packetAge <= packetAge + TimeWidth'(1);
		end
	end

endmodule

/* src/writeDataGen.sv */
// Write block generator for Update and Append commands
// Chunk i of the block carries seed plus i, low chunk first in each word
`timescale 1ns/100ps

module writeDataGen #(
	parameter int DBaseWidth = harnessPkg::DefDBaseWidth,
	parameter int FedWidth = harnessPkg::DefFedWidth,
	parameter int BlkChunks = harnessPkg::DefBlkChunks
) (
	input logic Clock,
	input logic arstN,
	input logic holdWrite,
	input logic [DBaseWidth-1:0] holdBase,
	input logic cmdTransfer,
	output logic [FedWidth-1:0] ORAMDataIn,
	output logic ORAMDataInValid,
	input logic ORAMDataInReady,
	output logic writeDone
);
	localparam int ChunksPerWord = FedWidth / DBaseWidth;
	localparam int WordsPerBlk = BlkChunks / ChunksPerWord;
	localparam int WordCntWidth = (WordsPerBlk > 1) ? $clog2(WordsPerBlk) : 1;

	logic [WordCntWidth-1:0] wordCnt;
	logic wordTransfer;
	logic lastWord;

	// Stream only while a write is held and its block is not yet out
	assign ORAMDataInValid = holdWrite & ~writeDone;
	assign wordTransfer = ORAMDataInValid & ORAMDataInReady;
	assign lastWord = wordCnt == WordCntWidth'(WordsPerBlk - 1);

	// --------------------
	// Word packing
	// --------------------

	// Built from held state, so steady under back-pressure
	always_comb begin
		for (int j = 0; j < ChunksPerWord; j++) begin
			ORAMDataIn[j*DBaseWidth +: DBaseWidth] =
				holdBase + DBaseWidth'(int'(wordCnt) * ChunksPerWord + j);
		end
	end

	// Word counter and block done flag
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			wordCnt <= '0;
			writeDone <= 1'b0;
		end else begin
			if (wordTransfer) begin
				if (lastWord) begin
					wordCnt <= '0;
				end else begin
					wordCnt <= wordCnt + WordCntWidth'(1);
				end
			end
			// Done until the command itself goes out
			if (cmdTransfer) begin
				writeDone <= 1'b0;
			end else if (wordTransfer && lastWord) begin
				writeDone <= 1'b1;
			end
		end
	end

endmodule

/* src/readChecker.sv */
// Read-back checker
// Compares each returned chunk with seed plus index and reports the block seed
`timescale 1ns/100ps

module readChecker #(
	parameter int DBaseWidth = harnessPkg::DefDBaseWidth,
	parameter int FedWidth = harnessPkg::DefFedWidth,
	parameter int BlkChunks = harnessPkg::DefBlkChunks
) (
	input logic Clock,
	input logic arstN,
	input logic [FedWidth-1:0] ORAMDataOut,
	input logic ORAMDataOutValid,
	output logic ORAMDataOutReady,
	output logic [DBaseWidth-1:0] ReadSeed,
	output logic ReadSeedValid,
	output logic ErrorReceivePattern
);
	localparam int ChunksPerWord = FedWidth / DBaseWidth;
	localparam int WordsPerBlk = BlkChunks / ChunksPerWord;
	localparam int WordCntWidth = (WordsPerBlk > 1) ? $clog2(WordsPerBlk) : 1;

	logic [WordCntWidth-1:0] wordCnt;
	logic [DBaseWidth-1:0] seedReg;
	logic [DBaseWidth-1:0] chunkBase;
	logic readyReg;
	logic wordTransfer;
	logic lastWord;
	logic mismatch;

	// Always accepting once out of reset
	assign ORAMDataOutReady = readyReg;
	assign wordTransfer = ORAMDataOutValid & ORAMDataOutReady;
	assign lastWord = wordCnt == WordCntWidth'(WordsPerBlk - 1);
	assign ReadSeed = seedReg;

	// First word brings its own seed in the low chunk
	assign chunkBase = (wordCnt == '0) ? ORAMDataOut[DBaseWidth-1:0] : seedReg;

	// --------------------
	// Per-chunk compare
	// --------------------

	always_comb begin
		mismatch = 1'b0;
		for (int j = 0; j < ChunksPerWord; j++) begin
			if (ORAMDataOut[j*DBaseWidth +: DBaseWidth] !=
					chunkBase + DBaseWidth'(int'(wordCnt) * ChunksPerWord + j)) begin
				mismatch = 1'b1;
			end
		end
	end

	// Seed capture, payload only
	always_ff @(posedge Clock) begin
		if (wordTransfer && wordCnt == '0) begin
			seedReg <= ORAMDataOut[DBaseWidth-1:0];
		end
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			readyReg <= 1'b0;
			wordCnt <= '0;
			ReadSeedValid <= 1'b0;
			ErrorReceivePattern <= 1'b0;
		end else begin
			readyReg <= 1'b1;
			// One-cycle pulse after the block's last word
			ReadSeedValid <= wordTransfer & lastWord;
			if (wordTransfer) begin
				wordCnt <= lastWord ? '0 : wordCnt + WordCntWidth'(1);
			end
			// Sticky
			if (wordTransfer && mismatch) begin
				ErrorReceivePattern <= 1'b1;
			end
		end
	end

endmodule

/* src/harnessTop.sv */
// Path-ORAM traffic harness top level
// Packet buffer, command issuer, write generator and read checker in a pipeline
`timescale 1ns/100ps

module harnessTop #(
	parameter int OramU = harnessPkg::DefOramU,
	parameter int DBaseWidth = harnessPkg::DefDBaseWidth,
	parameter int FedWidth = harnessPkg::DefFedWidth,
	parameter int BlkChunks = harnessPkg::DefBlkChunks,
	parameter int TimeWidth = harnessPkg::DefTimeWidth,
	parameter int Buffering = harnessPkg::DefBuffering
) (
	input logic Clock,
	input logic arstN,
	// Host packet port
	input logic [harnessPkg::CmdWidth+OramU+DBaseWidth+TimeWidth-1:0] PacketData,
	input logic PacketValid,
	output logic PacketReady,
	// Backend command
	output logic [harnessPkg::CmdWidth-1:0] ORAMCommand,
	output logic [OramU-1:0] ORAMPAddr,
	output logic ORAMCommandValid,
	input logic ORAMCommandReady,
	// Backend write data
	output logic [FedWidth-1:0] ORAMDataIn,
	output logic ORAMDataInValid,
	input logic ORAMDataInReady,
	// Backend read data
	input logic [FedWidth-1:0] ORAMDataOut,
	input logic ORAMDataOutValid,
	output logic ORAMDataOutReady,
	// Status
	output logic [DBaseWidth-1:0] ReadSeed,
	output logic ReadSeedValid,
	output logic ErrorSendOverflow,
	output logic ErrorReceivePattern
);
	import harnessPkg::*;

	// Buffer head toward the issuer
	logic [CmdWidth-1:0] headCmd;
	logic [OramU-1:0] headPAddr;
	logic [DBaseWidth-1:0] headBase;
	logic [TimeWidth-1:0] headDelay;
	logic headValid;
	logic headReady;

	// Issuer and write generator handshake
	logic holdWrite;
	logic [DBaseWidth-1:0] holdBase;
	logic cmdTransfer;
	logic writeDone;

	// --------------------
	// Send path
	// --------------------

	packetBuffer #(.OramU(OramU), .DBaseWidth(DBaseWidth), .TimeWidth(TimeWidth),
		.Buffering(Buffering)) uPacketBuffer (
		.Clock(Clock), .arstN(arstN),
		.PacketData(PacketData), .PacketValid(PacketValid), .PacketReady(PacketReady),
		.headCmd(headCmd), .headPAddr(headPAddr), .headBase(headBase),
		.headDelay(headDelay), .headValid(headValid), .headReady(headReady),
		.ErrorSendOverflow(ErrorSendOverflow));

	commandIssuer #(.OramU(OramU), .DBaseWidth(DBaseWidth), .TimeWidth(TimeWidth))
		uCommandIssuer (
		.Clock(Clock), .arstN(arstN),
		.headCmd(headCmd), .headPAddr(headPAddr), .headBase(headBase),
		.headDelay(headDelay), .headValid(headValid), .headReady(headReady),
		.ORAMCommand(ORAMCommand), .ORAMPAddr(ORAMPAddr),
		.ORAMCommandValid(ORAMCommandValid), .ORAMCommandReady(ORAMCommandReady),
		.writeDone(writeDone), .holdWrite(holdWrite), .holdBase(holdBase),
		.cmdTransfer(cmdTransfer));

	writeDataGen #(.DBaseWidth(DBaseWidth), .FedWidth(FedWidth), .BlkChunks(BlkChunks))
		uWriteDataGen (
		.Clock(Clock), .arstN(arstN),
		.holdWrite(holdWrite), .holdBase(holdBase), .cmdTransfer(cmdTransfer),
		.ORAMDataIn(ORAMDataIn), .ORAMDataInValid(ORAMDataInValid),
		.ORAMDataInReady(ORAMDataInReady), .writeDone(writeDone));

	// --------------------
	// Receive path
	// --------------------

	readChecker #(.DBaseWidth(DBaseWidth), .FedWidth(FedWidth), .BlkChunks(BlkChunks))
		uReadChecker (
		.Clock(Clock), .arstN(arstN),
		.ORAMDataOut(ORAMDataOut), .ORAMDataOutValid(ORAMDataOutValid),
		.ORAMDataOutReady(ORAMDataOutReady),
		.ReadSeed(ReadSeed), .ReadSeedValid(ReadSeedValid),
		.ErrorReceivePattern(ErrorReceivePattern));

endmodule

/* testbench/harnessChecker.sv */
// Scoreboard for the path-ORAM traffic harness
// Watches the backend side of the DUT and compares it against the harness rules
`timescale 1ns/100ps

module harnessChecker #(
	parameter int OramU = harnessPkg::DefOramU,
	parameter int DBaseWidth = harnessPkg::DefDBaseWidth,
	parameter int FedWidth = harnessPkg::DefFedWidth,
	parameter int BlkChunks = harnessPkg::DefBlkChunks,
	parameter int TimeWidth = harnessPkg::DefTimeWidth
) (
	input logic Clock,
	input logic arstN,
	input logic PacketReady,
	input logic [harnessPkg::CmdWidth-1:0] ORAMCommand,
	input logic [OramU-1:0] ORAMPAddr,
	input logic ORAMCommandValid,
	input logic ORAMCommandReady,
	input logic [FedWidth-1:0] ORAMDataIn,
	input logic ORAMDataInValid,
	input logic ORAMDataInReady,
	input logic ORAMDataOutValid,
	input logic ORAMDataOutReady,
	input logic [DBaseWidth-1:0] ReadSeed,
	input logic ReadSeedValid,
	input logic ErrorSendOverflow,
	input logic ErrorReceivePattern
);
	import harnessPkg::*;

	localparam int PacketWidth = CmdWidth + OramU + DBaseWidth + TimeWidth;
	localparam int ChunksPerWord = FedWidth / DBaseWidth;
	localparam int WordsPerBlk = BlkChunks / ChunksPerWord;

	// Released packets, oldest first
	logic [PacketWidth-1:0] cmdQueue [$];
	logic [DBaseWidth-1:0] seedQueue [$];
	logic corruptQueue [$];
	logic corruptSeen;
	int errorCount;
	int testErrors;
	int testCount;
	int checkCount;
	int cycle;
	int lastCmdCycle;
	int wordsSeen;

	initial begin
		corruptSeen = 1'b0;
		errorCount = 0;
		testErrors = 0;
		testCount = 0;
		checkCount = 0;
		cycle = 0;
		lastCmdCycle = -1;
		wordsSeen = 0;
	end

	// --------------------
	// Expectations from the testbench
	// --------------------

	task automatic expectCommand(input logic [PacketWidth-1:0] word);
		cmdQueue.push_back(word);
	endtask

	task automatic expectSeed(input logic [DBaseWidth-1:0] seed, input logic bad);
		seedQueue.push_back(seed);
		corruptQueue.push_back(bad);
	endtask

	function automatic bit idle();
		return cmdQueue.size() == 0 && seedQueue.size() == 0;
	endfunction

	// --------------------
	// Reporting
	// --------------------

	task automatic reportFailure(input string what);
		$display("error at cycle %0d: %s", cycle, what);
		errorCount++;
		testErrors++;
	endtask

	task automatic compareValue(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("error %s got %0h expected %0h at cycle %0d", name, got, exp, cycle);
			errorCount++;
			testErrors++;
		end
	endtask

	// Host port, sampled between clock edges while a packet is about to go in
	task automatic verifyPacketReady(input logic exp);
		compareValue("PacketReady", PacketReady, exp);
	endtask

	// Update and Append carry a data block
	function automatic bit isWrite(input logic [CmdWidth-1:0] cmd);
		return cmd == BecmdUpdate || cmd == BecmdAppend;
	endfunction

	// Chunk i of a block is seed plus i, low chunk first
	function automatic logic [FedWidth-1:0] expectedWord(input logic [DBaseWidth-1:0] seed,
			input int k);
		logic [FedWidth-1:0] w;
		for (int j = 0; j < ChunksPerWord; j++) begin
			w[j*DBaseWidth +: DBaseWidth] = seed + DBaseWidth'(k * ChunksPerWord + j);
		end
		return w;
	endfunction

	task automatic checkWriteWord();
		logic [PacketWidth-1:0] head;
		if (cmdQueue.size() == 0) begin
			reportFailure("write data appeared with no command pending");
		end else begin
			head = cmdQueue[0];
			if (!isWrite(head[PacketWidth-1 -: CmdWidth])) begin
				reportFailure("write data appeared ahead of a Read command");
			end else if (wordsSeen >= WordsPerBlk) begin
				reportFailure("more write words than one block");
			end else begin
				compareValue("ORAMDataIn", ORAMDataIn,
					expectedWord(head[TimeWidth +: DBaseWidth], wordsSeen));
			end
		end
		wordsSeen++;
	endtask

	task automatic checkCommand();
		logic [PacketWidth-1:0] head;
		logic [CmdWidth-1:0] cmd;
		int delay;
		int wantWords;
		if (cmdQueue.size() == 0) begin
			reportFailure("command issued with no packet released by a start");
		end else begin
			head = cmdQueue.pop_front();
			cmd = head[PacketWidth-1 -: CmdWidth];
			delay = int'(head[TimeWidth-1:0]);
			wantWords = isWrite(cmd) ? WordsPerBlk : 0;
			compareValue("ORAMCommand", ORAMCommand, cmd);
			compareValue("ORAMPAddr", ORAMPAddr, head[PacketWidth-CmdWidth-1 -: OramU]);
			if (wordsSeen != wantWords) begin
				reportFailure($sformatf("%0d write words ahead of the command, expected %0d",
					wordsSeen, wantWords));
			end
			// Time gate, at least delay plus 2 cycles between commands
			if (lastCmdCycle >= 0 && cycle - lastCmdCycle < delay + 2) begin
				reportFailure($sformatf("commands only %0d cycles apart, delay is %0d",
					cycle - lastCmdCycle, delay));
			end
		end
		lastCmdCycle = cycle;
		wordsSeen = 0;
	endtask

	task automatic checkReadSeed();
		logic [DBaseWidth-1:0] seed;
		if (seedQueue.size() == 0) begin
			reportFailure("seed returned with no read-back block expected");
		end else begin
			seed = seedQueue.pop_front();
			corruptSeen = corruptSeen | corruptQueue.pop_front();
			compareValue("ReadSeed", ReadSeed, seed);
			// Flag is sticky once any corrupted block went through
			compareValue("ErrorReceivePattern", ErrorReceivePattern, corruptSeen);
		end
	endtask

	// Sampled on the rising edge, inputs move on the falling one
	always @(posedge Clock) begin
		if (arstN) begin
			cycle++;
			if (ORAMDataInValid && ORAMDataInReady) begin
				checkWriteWord();
			end
			if (ORAMCommandValid && ORAMCommandReady) begin
				checkCommand();
			end
			if (ReadSeedValid) begin
				checkReadSeed();
			end
			// Read-back data always taken once out of reset
			if (ORAMDataOutValid) begin
				compareValue("ORAMDataOutReady", ORAMDataOutReady, 1'b1);
			end
		end
	end

	// End of one burst, flags checked against the expected sticky state
	task automatic closeTest(input logic overflowExp);
		compareValue("ErrorSendOverflow", ErrorSendOverflow, overflowExp);
		compareValue("ErrorReceivePattern", ErrorReceivePattern, corruptSeen);
		testCount++;
		$display("test %0d: %s, %0d errors", testCount, (testErrors == 0) ? "ok" : "bad",
			testErrors);
		testErrors = 0;
	endtask

	task automatic finalReport();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
	endtask

endmodule

/* testbench/harnessTb.sv */
// Testbench top for the path-ORAM traffic harness
// Replays the stimulus file, models the backend and hands expectations to the checker
`timescale 1ns/100ps

module harnessTb;
	import harnessPkg::*;

	localparam int OramU = DefOramU;
	localparam int DBaseWidth = DefDBaseWidth;
	localparam int FedWidth = DefFedWidth;
	localparam int BlkChunks = DefBlkChunks;
	localparam int TimeWidth = DefTimeWidth;
	localparam int Buffering = DefBuffering;
	localparam int PacketWidth = CmdWidth + OramU + DBaseWidth + TimeWidth;
	localparam int ChunksPerWord = FedWidth / DBaseWidth;
	localparam int WordsPerBlk = BlkChunks / ChunksPerWord;

	logic Clock;
	logic arstN;
	logic [PacketWidth-1:0] PacketData;
	logic PacketValid;
	logic PacketReady;
	logic [CmdWidth-1:0] ORAMCommand;
	logic [OramU-1:0] ORAMPAddr;
	logic ORAMCommandValid;
	logic ORAMCommandReady;
	logic [FedWidth-1:0] ORAMDataIn;
	logic ORAMDataInValid;
	logic ORAMDataInReady;
	logic [FedWidth-1:0] ORAMDataOut;
	logic ORAMDataOutValid;
	logic ORAMDataOutReady;
	logic [DBaseWidth-1:0] ReadSeed;
	logic ReadSeedValid;
	logic ErrorSendOverflow;
	logic ErrorReceivePattern;

	logic [31:0] lfsrState;
	logic throttle;
	int lineCount;
	int readsIssued;
	int readsServed;
	int fillModel;
	logic overflowExp;
	// Packets sent but not yet released by a start
	logic [PacketWidth-1:0] heldPackets [$];
	// Read-back blocks in file order
	logic [DBaseWidth-1:0] blockSeeds [$];
	logic blockCorrupt [$];

	harnessTop #(.OramU(OramU), .DBaseWidth(DBaseWidth), .FedWidth(FedWidth),
		.BlkChunks(BlkChunks), .TimeWidth(TimeWidth), .Buffering(Buffering)) DUT (
		.Clock(Clock), .arstN(arstN),
		.PacketData(PacketData), .PacketValid(PacketValid), .PacketReady(PacketReady),
		.ORAMCommand(ORAMCommand), .ORAMPAddr(ORAMPAddr),
		.ORAMCommandValid(ORAMCommandValid), .ORAMCommandReady(ORAMCommandReady),
		.ORAMDataIn(ORAMDataIn), .ORAMDataInValid(ORAMDataInValid),
		.ORAMDataInReady(ORAMDataInReady),
		.ORAMDataOut(ORAMDataOut), .ORAMDataOutValid(ORAMDataOutValid),
		.ORAMDataOutReady(ORAMDataOutReady),
		.ReadSeed(ReadSeed), .ReadSeedValid(ReadSeedValid),
		.ErrorSendOverflow(ErrorSendOverflow), .ErrorReceivePattern(ErrorReceivePattern));

	harnessChecker #(.OramU(OramU), .DBaseWidth(DBaseWidth), .FedWidth(FedWidth),
		.BlkChunks(BlkChunks), .TimeWidth(TimeWidth)) uChecker (
		.Clock(Clock), .arstN(arstN),
		.PacketReady(PacketReady),
		.ORAMCommand(ORAMCommand), .ORAMPAddr(ORAMPAddr),
		.ORAMCommandValid(ORAMCommandValid), .ORAMCommandReady(ORAMCommandReady),
		.ORAMDataIn(ORAMDataIn), .ORAMDataInValid(ORAMDataInValid),
		.ORAMDataInReady(ORAMDataInReady),
		.ORAMDataOutValid(ORAMDataOutValid), .ORAMDataOutReady(ORAMDataOutReady),
		.ReadSeed(ReadSeed), .ReadSeedValid(ReadSeedValid),
		.ErrorSendOverflow(ErrorSendOverflow), .ErrorReceivePattern(ErrorReceivePattern));

	// 20 ns period
	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	// Galois form, taps for x^32 + x^30 + x^26 + x^25 + 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
	endfunction

	// Read-back word k of a block; corruption hits the top chunk of the last word
	function automatic logic [FedWidth-1:0] blockWord(input logic [DBaseWidth-1:0] seed,
			input int k, input logic bad);
		logic [FedWidth-1:0] w;
		for (int j = 0; j < ChunksPerWord; j++) begin
			w[j*DBaseWidth +: DBaseWidth] = seed + DBaseWidth'(k * ChunksPerWord + j);
		end
		if (bad && k == WordsPerBlk - 1) begin
			w[FedWidth-1] = ~w[FedWidth-1];
		end
		return w;
	endfunction

	// One packet, valid for a single cycle, ready or not
	task automatic drivePacket(input logic [PacketWidth-1:0] word);
		PacketData = word;
		PacketValid = 1'b1;
		@(negedge Clock);
		PacketValid = 1'b0;
	endtask

	// Release the held packets with a start and wait for the burst to drain
	task automatic runBurst(input logic squeeze);
		logic [PacketWidth-1:0] word;
		// Quiet spell, nothing may issue before the start
		repeat (8) @(negedge Clock);
		throttle <= squeeze;
		while (heldPackets.size() > 0) begin
			word = heldPackets.pop_front();
			uChecker.expectCommand(word);
		end
		drivePacket({TcmdStart, (PacketWidth - CmdWidth)'(0)});
		while (!uChecker.idle() || readsServed != readsIssued) begin
			@(negedge Clock);
		end
		// Let the burst gate close again
		repeat (4) @(negedge Clock);
		throttle <= 1'b0;
		fillModel = 0;
		uChecker.closeTest(overflowExp);
	endtask

	// --------------------
	// Backend model
	// --------------------

	// Ready lines, one LFSR bit each per falling edge
	always @(negedge Clock) begin
		if (throttle) begin
			ORAMCommandReady = lfsrState[0];
			lfsrState = stepLfsr(lfsrState);
			ORAMDataInReady = lfsrState[0];
			lfsrState = stepLfsr(lfsrState);
		end else begin
			ORAMCommandReady = 1'b1;
			ORAMDataInReady = 1'b1;
		end
	end

	// Count accepted Read commands
	always @(posedge Clock) begin
		if (arstN && ORAMCommandValid && ORAMCommandReady && ORAMCommand == BecmdRead) begin
			readsIssued <= readsIssued + 1;
		end
	end

	// Answer each Read with the next listed block
	initial begin : readBackModel
		logic [DBaseWidth-1:0] seed;
		logic bad;
		forever begin
			@(negedge Clock);
			if (readsIssued > readsServed && blockSeeds.size() > 0) begin
				seed = blockSeeds.pop_front();
				bad = blockCorrupt.pop_front();
				for (int k = 0; k < WordsPerBlk; k++) begin
					ORAMDataOut = blockWord(seed, k, bad);
					ORAMDataOutValid = 1'b1;
					@(posedge Clock);
					while (!ORAMDataOutReady) begin
						@(posedge Clock);
					end
					@(negedge Clock);
				end
				ORAMDataOutValid = 1'b0;
				readsServed++;
			end
		end
	end

	// Watchdog, budget per stimulus line covers the longest delay plus a block
	initial begin : watchdog
		wait (lineCount > 0);
		repeat (lineCount * (255 + WordsPerBlk + 20)) @(posedge Clock);
		$display("timeout, the DUT did not finish %0d stimulus lines in time", lineCount);
		$display("sim failed");
		$finish;
	end

	// --------------------
	// Main sequence
	// --------------------

	// Packets, read-back blocks and start markers in file order
	task automatic replayStimulus(input int fd);
		int code;
		string kind;
		string rest;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [PacketWidth-1:0] word;
		while ($fscanf(fd, "%s", kind) == 1) begin
			if (kind == "P") begin
				code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
				word = {f0[CmdWidth-1:0], f1[OramU-1:0], f2[DBaseWidth-1:0], f3[TimeWidth-1:0]};
				// Host port ready only while the FIFO has room
				uChecker.verifyPacketReady(fillModel < Buffering);
				// FIFO full, packet dropped and flagged
				if (fillModel == Buffering) begin
					overflowExp = 1'b1;
				end else begin
					heldPackets.push_back(word);
					fillModel++;
				end
				drivePacket(word);
			end else if (kind == "R") begin
				code = $fscanf(fd, "%h %h", f0, f1);
				blockSeeds.push_back(f0[DBaseWidth-1:0]);
				blockCorrupt.push_back(f1[0]);
				uChecker.expectSeed(f0[DBaseWidth-1:0], f1[0]);
			end else if (kind == "S") begin
				code = $fscanf(fd, "%h", f0);
				runBurst(f0[0]);
			end else begin
				// Comment line
				code = $fgets(rest, fd);
			end
		end
	endtask

	initial begin : mainSequence
		int fd;
		int code;
		int lines;
		string rest;
		arstN = 1'b0;
		PacketData = '0;
		PacketValid = 1'b0;
		ORAMCommandReady = 1'b1;
		ORAMDataInReady = 1'b1;
		ORAMDataOut = '0;
		ORAMDataOutValid = 1'b0;
		lfsrState = 32'hf362_ef71;
		throttle = 1'b0;
		readsIssued = 0;
		readsServed = 0;
		fillModel = 0;
		overflowExp = 1'b0;
		lineCount = 0;
		fd = $fopen("testbench/harnessStimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			$display("sim failed");
		end else begin
			// Size the watchdog from the file length
			lines = 0;
			while (!$feof(fd)) begin
				code = $fgets(rest, fd);
				if (code > 0) begin
					lines++;
				end
			end
			$fclose(fd);
			lineCount = lines;
			repeat (4) @(negedge Clock);
			arstN = 1'b1;
			repeat (2) @(negedge Clock);
			fd = $fopen("testbench/harnessStimulus.txt", "r");
			replayStimulus(fd);
			$fclose(fd);
			repeat (4) @(negedge Clock);
			uChecker.finalReport();
			if (uChecker.errorCount == 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
		end
		$finish;
	end

endmodule

/* testbench/harnessStimulus.txt */
# P cmd leaf seed delay : host packet in hex, cmd 0 Read, 1 Update, 2 Append
# R seed corrupt : block for the next Read; S throttle : start packet, 1 adds back-pressure
# burst 1, backend always ready
P 1 2a 1000 03
P 0 2a 0000 00
P 2 91 2000 10
P 0 91 0000 05
R 1000 0
R 2000 0
S 0
# burst 2, LFSR back-pressure, seeds wrap
P 0 07 0000 02
P 1 08 abcd 00
P 2 ff fff9 07
P 0 40 0000 ff
R 3e00 0
R fffc 0
S 1
# burst 3, Buffering plus 2 packets before the start, last two dropped
P 1 01 0100 00
P 2 02 0200 01
P 1 03 0300 02
P 2 04 0400 03
P 1 05 0500 00
P 2 06 0600 01
P 1 07 0700 02
P 2 08 0800 03
P 1 09 0900 00
P 2 0a 0a00 01
P 1 0b 0b00 02
P 2 0c 0c00 03
P 1 0d 0d00 00
P 2 0e 0e00 01
P 1 0f 0f00 02
P 2 10 1000 03
P 1 11 1100 00
P 2 12 1200 01
S 1
# burst 4, corrupted read-back block
P 0 55 0000 01
R 7777 1
S 0

/* list.f */
src/harnessPkg.sv
src/packetBuffer.sv
src/commandIssuer.sv
src/writeDataGen.sv
src/readChecker.sv
src/harnessTop.sv
testbench/harnessChecker.sv
testbench/harnessTb.sv
